/* Makefile */
# Verilator build for the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_data_cache
FILELIST  ?= data_cache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cache_array.sv */
module cache_array #(
    parameter int cache_depth    = 16,
    parameter int data_width     = 16,
    parameter int mem_addr_width = 16,
    parameter int col_addr_width = 8,
    parameter int idx_width      = $clog2(cache_depth)
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [mem_addr_width-1:0] data_addr,
    input  logic [col_addr_width-1:0] addr_cam_col,
    input  logic [data_width-1:0]     data_out_rbr,
    input  logic [cache_depth-1:0]    data_out_cbc,
    input  logic [data_width-1:0]     data_to_cache,
    input  logic [idx_width-1:0]      burst_idx,
    input  logic                      row_we,
    input  logic                      col_we,
    input  logic                      fill_we,
    output logic [data_width-1:0]     row_rdata,
    output logic [cache_depth-1:0]    col_rdata,
    output logic [data_width-1:0]     store_rdata
);

    localparam int col_sel_width = $clog2(data_width);

    logic [data_width-1:0]    rows [cache_depth];
    logic [idx_width-1:0]     row_idx;
    logic [col_sel_width-1:0] col_idx;

    assign row_idx = data_addr[idx_width-1:0];
    assign col_idx = addr_cam_col[col_sel_width-1:0];   // Bit position within each row

    // ====================
    // Write ports
    // ====================

    // The controller never raises two write enables in the same cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int r = 0; r < cache_depth; r++) begin
                rows[r] <= '0;
            end
        end else begin
            if (row_we) begin
                rows[row_idx] <= data_out_rbr;
            end
            if (fill_we) begin
                rows[burst_idx] <= data_to_cache;   // Gap cycles are overwritten by the next valid beat
            end
            if (col_we) begin
                for (int r = 0; r < cache_depth; r++) begin
                    rows[r][col_idx] <= data_out_cbc[r];
                end
            end
        end
    end

    // ====================
    // Read ports
    // ====================

    assign row_rdata   = rows[row_idx];
    assign store_rdata = rows[burst_idx];   // Row being written back

    always_comb begin
        for (int r = 0; r < cache_depth; r++) begin
            col_rdata[r] = rows[r][col_idx];   // Row r supplies bit r of the column
        end
    end

endmodule

/* cache_ctrl.sv */
module cache_ctrl
    import data_cache_pkg::*;
#(
    parameter int cache_depth = 16,
    parameter int data_width  = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  dc_cmd_t                data_cmd,
    input  logic                   store_ddr_en,
    input  logic                   hit,
    input  logic                   burst_done,
    input  logic [data_width-1:0]  row_rdata,
    input  logic [cache_depth-1:0] col_rdata,
    output logic                   data_cache_rdy,
    output logic [data_width-1:0]  data_in_rbr,
    output logic [cache_depth-1:0] data_in_cbc,
    output logic                   tag_load,
    output logic                   row_we,
    output logic                   col_we,
    output logic                   fill_we,
    output logic                   fill_start,
    output logic                   store_start
);

    dc_state_t st_cur;
    dc_state_t st_next;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            st_cur <= st_idle;
        end else begin
            st_cur <= st_next;
        end
    end

    // ====================
    // Next state and strobes
    // ====================

    always_comb begin
        st_next        = st_cur;
        data_cache_rdy = 1'b0;
        tag_load       = 1'b0;
        row_we         = 1'b0;
        col_we         = 1'b0;
        fill_we        = 1'b0;
        fill_start     = 1'b0;
        store_start    = 1'b0;
        case (st_cur)
            st_idle: begin
                case (data_cmd)
                    cmd_row_load: begin
                        if (hit) begin
                            st_next = st_row_send;
                        end else begin
                            st_next    = st_fill;   // Miss brings the whole block in first
                            fill_start = 1'b1;
                            tag_load   = 1'b1;
                        end
                    end
                    cmd_row_store: st_next = st_row_get;
                    cmd_col_load:  st_next = st_col_send;
                    cmd_col_store: st_next = st_col_get;
                    cmd_nop: begin
                        if (store_ddr_en) begin
                            st_next     = st_store;
                            store_start = 1'b1;
                        end
                    end
                    default: st_next = st_idle;
                endcase
            end
            st_fill: begin
                fill_we = 1'b1;
                if (burst_done) begin
                    st_next = st_row_send;
                end
            end
            st_row_send, st_col_send, st_store_end: begin
                data_cache_rdy = 1'b1;
                st_next        = st_idle;
            end
            st_row_get: begin
                row_we         = 1'b1;
                tag_load       = 1'b1;   // Written row claims the block without a fill
                data_cache_rdy = 1'b1;
                st_next        = st_idle;
            end
            st_col_get: begin
                col_we         = 1'b1;
                data_cache_rdy = 1'b1;
                st_next        = st_idle;
            end
            st_store: begin
                if (burst_done) begin
                    st_next = st_store_end;
                end
            end
            default: st_next = st_idle;
        endcase
    end

    // Read data is only driven alongside its ready pulse
    assign data_in_rbr = (st_cur == st_row_send) ? row_rdata : '0;
    assign data_in_cbc = (st_cur == st_col_send) ? col_rdata : '0;

endmodule

/* data_cache.f */
data_cache_pkg.sv
tag_store.sv
cache_array.sv
ddr_burst.sv
cache_ctrl.sv
data_cache_top.sv
tb_ddr_model.sv
tb_data_cache.sv

/* data_cache_pkg.sv */
package data_cache_pkg;

    // ====================
    // Processor commands
    // ====================

    typedef enum logic [2:0] {
        cmd_nop       = 3'd0,
        cmd_row_load  = 3'd1,   // Return one row, fill the block first on a miss
        cmd_row_store = 3'd2,
        cmd_col_load  = 3'd3,   // Gather one bit position from every row
        cmd_col_store = 3'd4
    } dc_cmd_t;

    // ====================
    // Controller states
    // ====================

    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_row_send  = 3'd1,
        st_col_send  = 3'd2,
        st_fill      = 3'd3,    // Read burst from DDR in progress
        st_row_get   = 3'd4,
        st_col_get   = 3'd5,
        st_store     = 3'd6,    // Write-back burst to DDR in progress
        st_store_end = 3'd7
    } dc_state_t;

    // Beat counter width shared by the fill and write-back bursts
    localparam int rd_cnt_width = 10;

endpackage

/* data_cache_top.sv */
module data_cache_top
    import data_cache_pkg::*;
#(
    parameter int cache_depth    = 16,
    parameter int data_width     = 16,
    parameter int mem_addr_width = 16,
    parameter int ddr_addr_width = 28,
    parameter int col_addr_width = 8
) (
    input  logic                      clk,
    input  logic                      rst,

    // Processor side
    input  dc_cmd_t                   data_cmd,
    input  logic [mem_addr_width-1:0] data_addr,
    input  logic [col_addr_width-1:0] addr_cam_col,
    input  logic [data_width-1:0]     data_out_rbr,
    input  logic [cache_depth-1:0]    data_out_cbc,
    input  logic                      store_ddr_en,
    output logic                      data_cache_rdy,
    output logic [data_width-1:0]     data_in_rbr,
    output logic [cache_depth-1:0]    data_in_cbc,

    // DDR side
    output logic                      data_read_req,
    output logic [ddr_addr_width-1:0] data_read_addr,
    input  logic [data_width-1:0]     data_to_cache,
    input  logic                      rd_burst_data_valid,
    output logic                      data_store_req,
    output logic [ddr_addr_width-1:0] data_write_addr,
    output logic [data_width-1:0]     data_to_ddr
);

    localparam int idx_width = $clog2(cache_depth);
    localparam int tag_width = mem_addr_width - idx_width;

    logic                   hit;
    logic [tag_width-1:0]   tag;
    logic                   tag_load;
    logic                   row_we;
    logic                   col_we;
    logic                   fill_we;
    logic                   fill_start;
    logic                   store_start;
    logic [idx_width-1:0]   burst_idx;
    logic                   burst_done;
    logic [data_width-1:0]  row_rdata;
    logic [cache_depth-1:0] col_rdata;

    tag_store #(
        .cache_depth    (cache_depth),
        .mem_addr_width (mem_addr_width)
    ) u_tag_store (
        .clk       (clk),
        .rst       (rst),
        .data_addr (data_addr),
        .tag_load  (tag_load),
        .hit       (hit),
        .tag       (tag)
    );

    cache_array #(
        .cache_depth    (cache_depth),
        .data_width     (data_width),
        .mem_addr_width (mem_addr_width),
        .col_addr_width (col_addr_width)
    ) u_cache_array (
        .clk           (clk),
        .rst           (rst),
        .data_addr     (data_addr),
        .addr_cam_col  (addr_cam_col),
        .data_out_rbr  (data_out_rbr),
        .data_out_cbc  (data_out_cbc),
        .data_to_cache (data_to_cache),
        .burst_idx     (burst_idx),
        .row_we        (row_we),
        .col_we        (col_we),
        .fill_we       (fill_we),
        .row_rdata     (row_rdata),
        .col_rdata     (col_rdata),
        .store_rdata   (data_to_ddr)
    );

    ddr_burst #(
        .cache_depth    (cache_depth),
        .mem_addr_width (mem_addr_width),
        .ddr_addr_width (ddr_addr_width)
    ) u_ddr_burst (
        .clk                 (clk),
        .rst                 (rst),
        .tag                 (tag),
        .fill_start          (fill_start),
        .store_start         (store_start),
        .rd_burst_data_valid (rd_burst_data_valid),
        .burst_idx           (burst_idx),
        .burst_done          (burst_done),
        .data_read_addr      (data_read_addr),
        .data_write_addr     (data_write_addr),
        .data_read_req       (data_read_req),
        .data_store_req      (data_store_req)
    );

    cache_ctrl #(
        .cache_depth (cache_depth),
        .data_width  (data_width)
    ) u_cache_ctrl (
        .clk            (clk),
        .rst            (rst),
        .data_cmd       (data_cmd),
        .store_ddr_en   (store_ddr_en),
        .hit            (hit),
        .burst_done     (burst_done),
        .row_rdata      (row_rdata),
        .col_rdata      (col_rdata),
        .data_cache_rdy (data_cache_rdy),
        .data_in_rbr    (data_in_rbr),
        .data_in_cbc    (data_in_cbc),
        .tag_load       (tag_load),
        .row_we         (row_we),
        .col_we         (col_we),
        .fill_we        (fill_we),
        .fill_start     (fill_start),
        .store_start    (store_start)
    );

endmodule

/* ddr_burst.sv */
module ddr_burst
    import data_cache_pkg::*;
#(
    parameter int cache_depth    = 16,
    parameter int mem_addr_width = 16,
    parameter int ddr_addr_width = 28,
    parameter int idx_width      = $clog2(cache_depth),
    parameter int tag_width      = mem_addr_width - idx_width
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [tag_width-1:0]      tag,
    input  logic                      fill_start,
    input  logic                      store_start,
    input  logic                      rd_burst_data_valid,
    output logic [idx_width-1:0]      burst_idx,
    output logic                      burst_done,
    output logic [ddr_addr_width-1:0] data_read_addr,
    output logic [ddr_addr_width-1:0] data_write_addr,
    output logic                      data_read_req,
    output logic                      data_store_req
);

    localparam logic [rd_cnt_width-1:0] last_beat = rd_cnt_width'(cache_depth - 1);

    logic [rd_cnt_width-1:0]   beat_cnt;
    logic                      beat;
    logic [mem_addr_width-1:0] block_base;

    // A fill advances on valid beats, a write-back on every cycle
    assign beat       = (data_read_req && rd_burst_data_valid) || data_store_req;
    assign burst_done = beat && (beat_cnt == last_beat);
    assign burst_idx  = beat_cnt[idx_width-1:0];

    // ====================
    // Beat counter
    // ====================

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            data_read_req  <= 1'b0;
            data_store_req <= 1'b0;
            beat_cnt       <= '0;
        end else if (fill_start) begin
            data_read_req <= 1'b1;
            beat_cnt      <= '0;
        end else if (store_start) begin
            data_store_req <= 1'b1;
            beat_cnt       <= '0;
        end else if (beat) begin
            if (burst_done) begin
                data_read_req  <= 1'b0;   // Request drops once the whole block has moved
                data_store_req <= 1'b0;
                beat_cnt       <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // ====================
    // DDR block address
    // ====================

    assign block_base      = {tag, {idx_width{1'b0}}};
    assign data_read_addr  = ddr_addr_width'(block_base);
    assign data_write_addr = ddr_addr_width'(block_base);   // Same block for fill and write-back

endmodule

/* tag_store.sv */
module tag_store #(
    parameter int cache_depth    = 16,
    parameter int mem_addr_width = 16,
    parameter int idx_width      = $clog2(cache_depth),
    parameter int tag_width      = mem_addr_width - idx_width
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [mem_addr_width-1:0] data_addr,
    input  logic                      tag_load,
    output logic                      hit,
    output logic [tag_width-1:0]      tag
);

    logic                 tag_valid;
    logic [tag_width-1:0] addr_tag;

    assign addr_tag = data_addr[mem_addr_width-1:idx_width];   // Row index bits sit below the tag

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tag       <= '0;
            tag_valid <= 1'b0;
        end else if (tag_load) begin
            tag       <= addr_tag;
            tag_valid <= 1'b1;
        end
    end

    // Block is present only once a tag has been loaded
    assign hit = tag_valid && (addr_tag == tag);

endmodule

/* tb_data_cache.sv */
module tb_data_cache
    import data_cache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int cache_depth    = 16;
    localparam int data_width     = 16;
    localparam int mem_addr_width = 16;
    localparam int ddr_addr_width = 28;
    localparam int col_addr_width = 8;
    localparam int idx_width      = $clog2(cache_depth);
    localparam int tag_width      = mem_addr_width - idx_width;
    localparam int col_sel_width  = $clog2(data_width);
    localparam int hit_latency    = 2;                 // Drive edge to the edge that sees ready
    localparam int store_latency  = cache_depth + 2;
    localparam int cycle_limit    = 40 * 40 + 400;     // 40 commands of up to 40 cycles

    logic                      clk = 1'b0;
    logic                      rst;
    dc_cmd_t                   data_cmd;
    logic [mem_addr_width-1:0] data_addr;
    logic [col_addr_width-1:0] addr_cam_col;
    logic [data_width-1:0]     data_out_rbr;
    logic [cache_depth-1:0]    data_out_cbc;
    logic                      store_ddr_en;
    logic                      data_cache_rdy;
    logic [data_width-1:0]     data_in_rbr;
    logic [cache_depth-1:0]    data_in_cbc;
    logic                      data_read_req;
    logic [ddr_addr_width-1:0] data_read_addr;
    logic [data_width-1:0]     data_to_cache;
    logic                      rd_burst_data_valid;
    logic                      data_store_req;
    logic [ddr_addr_width-1:0] data_write_addr;
    logic [data_width-1:0]     data_to_ddr;
    int                        store_beats;

    // Reference state and expectations for the command in flight
    logic [data_width-1:0]     ddr_ref [2**mem_addr_width];
    logic [data_width-1:0]     ref_rows [cache_depth];
    logic [tag_width-1:0]      ref_tag;
    logic                      ref_valid;
    logic [15:0]               lfsr;
    dc_cmd_t                   exp_cmd;
    logic                      exp_wb;
    logic                      expect_fill;
    logic [data_width-1:0]     exp_row;
    logic [cache_depth-1:0]    exp_col;
    logic [ddr_addr_width-1:0] exp_addr;
    int                        cmd_cycle;
    int                        cycle_cnt = 0;
    int                        n_issued = 0;
    int                        rdy_total = 0;
    int                        store_idx = 0;
    int                        fill_cycles = 0;
    logic                      prev_rdy = 1'b0;

    always #20 clk = ~clk;

    data_cache_top #(
        .cache_depth    (cache_depth),
        .data_width     (data_width),
        .mem_addr_width (mem_addr_width),
        .ddr_addr_width (ddr_addr_width),
        .col_addr_width (col_addr_width)
    ) UUT (
        .clk                 (clk),
        .rst                 (rst),
        .data_cmd            (data_cmd),
        .data_addr           (data_addr),
        .addr_cam_col        (addr_cam_col),
        .data_out_rbr        (data_out_rbr),
        .data_out_cbc        (data_out_cbc),
        .store_ddr_en        (store_ddr_en),
        .data_cache_rdy      (data_cache_rdy),
        .data_in_rbr         (data_in_rbr),
        .data_in_cbc         (data_in_cbc),
        .data_read_req       (data_read_req),
        .data_read_addr      (data_read_addr),
        .data_to_cache       (data_to_cache),
        .rd_burst_data_valid (rd_burst_data_valid),
        .data_store_req      (data_store_req),
        .data_write_addr     (data_write_addr),
        .data_to_ddr         (data_to_ddr)
    );

    tb_ddr_model #(
        .cache_depth    (cache_depth),
        .data_width     (data_width),
        .mem_addr_width (mem_addr_width),
        .ddr_addr_width (ddr_addr_width)
    ) ddr (
        .clk                 (clk),
        .rst                 (rst),
        .data_read_req       (data_read_req),
        .data_read_addr      (data_read_addr),
        .data_to_cache       (data_to_cache),
        .rd_burst_data_valid (rd_burst_data_valid),
        .data_store_req      (data_store_req),
        .data_to_ddr         (data_to_ddr),
        .store_beats         (store_beats)
    );

    // ====================
    // Random numbers
    // ====================

    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // ====================
    // Reference model
    // ====================

    function automatic logic [ddr_addr_width-1:0] block_addr(input logic [tag_width-1:0] t);
        return ddr_addr_width'({t, {idx_width{1'b0}}});
    endfunction

    function automatic void ref_model(
        input  dc_cmd_t                   cmd,
        input  logic [mem_addr_width-1:0] addr,
        input  logic [col_addr_width-1:0] col,
        input  logic [data_width-1:0]     rbr,
        input  logic [cache_depth-1:0]    cbc,
        input  logic                      wb,
        output logic [data_width-1:0]     row_o,
        output logic [cache_depth-1:0]    col_o,
        output logic                      fill_o,
        output logic [ddr_addr_width-1:0] ddr_o
    );
        logic [tag_width-1:0]     t;
        logic [idx_width-1:0]     idx;
        logic [col_sel_width-1:0] csel;
        t      = addr[mem_addr_width-1:idx_width];
        idx    = addr[idx_width-1:0];
        csel   = col[col_sel_width-1:0];
        row_o  = '0;
        col_o  = '0;
        fill_o = 1'b0;
        ddr_o  = block_addr(ref_tag);   // Write-back uses the block currently held
        if (!wb) begin
            case (cmd)
                cmd_row_load: begin
                    if (!(ref_valid && t == ref_tag)) begin
                        fill_o    = 1'b1;
                        ref_tag   = t;
                        ref_valid = 1'b1;
                        for (int r = 0; r < cache_depth; r++) begin
                            ref_rows[idx_width'(r)] = ddr_ref[{t, idx_width'(r)}];
                        end
                    end
                    row_o = ref_rows[idx];
                    ddr_o = block_addr(t);
                end
                cmd_row_store: begin
                    ref_rows[idx] = rbr;
                    ref_tag       = t;
                    ref_valid     = 1'b1;
                end
                cmd_col_store: begin
                    for (int r = 0; r < cache_depth; r++) begin
                        ref_rows[idx_width'(r)][csel] = cbc[idx_width'(r)];
                    end
                end
                cmd_col_load: begin
                    for (int r = 0; r < cache_depth; r++) begin
                        col_o[idx_width'(r)] = ref_rows[idx_width'(r)][csel];
                    end
                end
                default: ;
            endcase
        end
    endfunction

    // ====================
    // Compare tasks
    // ====================

    task automatic report_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_row(input logic [data_width-1:0] got, exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s row 0x%h, expected 0x%h", what, got, exp));
        end
    endtask

    task automatic check_col(input logic [cache_depth-1:0] got, exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s column 0x%h, expected 0x%h", what, got, exp));
        end
    endtask

    task automatic check_ddr_addr(input logic [ddr_addr_width-1:0] got, exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s address 0x%h, expected 0x%h", what, got, exp));
        end
    endtask

    task automatic check_store_beat(
        input logic [data_width-1:0]     got,
        input logic [ddr_addr_width-1:0] got_addr,
        input logic [data_width-1:0]     exp,
        input logic [ddr_addr_width-1:0] exp_addr_i,
        input int                        beat
    );
        check_ddr_addr(got_addr, exp_addr_i, "write-back");
        if (got !== exp) begin
            report_error($sformatf("write-back beat %0d 0x%h, expected 0x%h", beat, got, exp));
        end
    endtask

    task automatic check_rdy_cycles(input int got, exp, input string what);
        if (got != exp) begin
            report_error($sformatf("%s %0d cycles, expected %0d", what, got, exp));
        end
    endtask

    // ====================
    // Compare process
    // ====================

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            report_failure("Timeout: the data cache did not finish its commands in time");
        end
    end

    always @(posedge clk) begin
        int latency;
        latency = cycle_cnt - cmd_cycle;
        if (rst === 1'b1) begin
            if (data_read_req) begin
                if (!expect_fill) begin
                    report_failure("A DDR read request was raised for a command that hits");
                end
                check_ddr_addr(data_read_addr, exp_addr, "fill read");
                fill_cycles++;
            end
            if (data_store_req) begin
                if (!exp_wb) begin
                    report_failure("A DDR store request was raised without a write-back");
                end
                check_store_beat(data_to_ddr, data_write_addr, ref_rows[idx_width'(store_idx)],
                                 exp_addr, store_idx);
                store_idx++;
            end
            if (data_cache_rdy) begin
                if (prev_rdy) begin
                    report_failure("data_cache_rdy stayed high for more than one cycle");
                end
                rdy_total++;
                if (exp_wb) begin
                    check_rdy_cycles(store_idx, cache_depth, "store request held");
                    check_rdy_cycles(latency, store_latency, "write-back latency");
                end else if (expect_fill) begin
                    if (fill_cycles == 0) begin
                        report_failure("A row read miss finished without a DDR read request");
                    end
                    check_row(data_in_rbr, exp_row, "miss read");
                end else begin
                    check_rdy_cycles(latency, hit_latency, "command latency");
                    if (exp_cmd == cmd_row_load) begin
                        check_row(data_in_rbr, exp_row, "hit read");
                    end
                    if (exp_cmd == cmd_col_load) begin
                        check_col(data_in_cbc, exp_col, "column read");
                    end
                end
                store_idx   = 0;
                fill_cycles = 0;
            end
            prev_rdy = data_cache_rdy;
        end
    end

    // ====================
    // Stimulus
    // ====================

    task automatic run_cmd(
        input dc_cmd_t                   cmd,
        input logic [mem_addr_width-1:0] addr,
        input logic [col_addr_width-1:0] col,
        input logic [data_width-1:0]     rbr,
        input logic [cache_depth-1:0]    cbc,
        input logic                      wb
    );
        logic [data_width-1:0]     row_e;
        logic [cache_depth-1:0]    col_e;
        logic                      fill_e;
        logic [ddr_addr_width-1:0] addr_e;
        @(posedge clk);
        ref_model(cmd, addr, col, rbr, cbc, wb, row_e, col_e, fill_e, addr_e);
        exp_cmd      <= cmd;
        exp_wb       <= wb;
        expect_fill  <= fill_e;
        exp_row      <= row_e;
        exp_col      <= col_e;
        exp_addr     <= addr_e;
        cmd_cycle    <= cycle_cnt;
        data_cmd     <= cmd;
        data_addr    <= addr;
        addr_cam_col <= col;
        data_out_rbr <= rbr;
        data_out_cbc <= cbc;
        store_ddr_en <= wb;
        n_issued++;
        do begin
            @(posedge clk);
        end while (data_cache_rdy !== 1'b1);
        data_cmd     <= cmd_nop;   // Command drops at the edge that sees ready
        store_ddr_en <= 1'b0;
    endtask

    initial begin
        logic [mem_addr_width-1:0] addr_a;
        logic [mem_addr_width-1:0] addr_b;
        logic [mem_addr_width-1:0] addr_w;
        logic [col_addr_width-1:0] col;
        logic [cache_depth-1:0]    cbc;
        rst          <= 1'b0;
        data_cmd     <= cmd_nop;
        data_addr    <= '0;
        addr_cam_col <= '0;
        data_out_rbr <= '0;
        data_out_cbc <= '0;
        store_ddr_en <= 1'b0;
        exp_cmd      <= cmd_nop;
        exp_wb       <= 1'b0;
        expect_fill  <= 1'b0;
        exp_row      <= '0;
        exp_col      <= '0;
        exp_addr     <= '0;
        cmd_cycle    <= 0;
        ref_tag      = '0;
        ref_valid    = 1'b0;
        lfsr         = 16'd96;
        for (int a = 0; a < 2**mem_addr_width; a++) begin
            ddr_ref[mem_addr_width'(a)] = data_width'(rand_bits(data_width));
            ddr.ddr_mem[mem_addr_width'(a)] = ddr_ref[mem_addr_width'(a)];
        end
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        if (data_cache_rdy !== 1'b0 || data_read_req !== 1'b0 || data_store_req !== 1'b0) begin
            report_failure("A control output was not low after reset");
        end
        check_row(data_in_rbr, '0, "after reset");
        check_col(data_in_cbc, '0, "after reset");

        addr_a = mem_addr_width'(rand_bits(mem_addr_width));
        run_cmd(cmd_row_load, addr_a, '0, '0, '0, 1'b0);   // Cold miss fills the block
        for (int i = 0; i < 4; i++) begin
            addr_w = {addr_a[mem_addr_width-1:idx_width], idx_width'(rand_bits(idx_width))};
            run_cmd(cmd_row_load, addr_w, '0, '0, '0, 1'b0);
        end
        for (int i = 0; i < 2; i++) begin
            addr_w = {addr_a[mem_addr_width-1:idx_width], idx_width'(rand_bits(idx_width))};
            run_cmd(cmd_row_store, addr_w, '0, data_width'(rand_bits(data_width)), '0, 1'b0);
            run_cmd(cmd_row_load, addr_w, '0, '0, '0, 1'b0);
        end
        col = col_addr_width'(rand_bits(col_sel_width));
        cbc = cache_depth'(rand_bits(cache_depth));
        run_cmd(cmd_col_store, addr_a, col, '0, cbc, 1'b0);
        run_cmd(cmd_col_load, addr_a, col, '0, '0, 1'b0);
        for (int r = 0; r < cache_depth; r++) begin
            addr_w = {addr_a[mem_addr_width-1:idx_width], idx_width'(r)};
            run_cmd(cmd_row_load, addr_w, '0, '0, '0, 1'b0);
        end
        run_cmd(cmd_nop, addr_a, '0, '0, '0, 1'b1);   // Write-back of the whole block
        for (int r = 0; r < cache_depth; r++) begin
            check_row(ddr.store_log[r], ref_rows[idx_width'(r)], "DDR copy of write-back");
        end

        addr_b = mem_addr_width'(rand_bits(mem_addr_width));
        addr_b[mem_addr_width-1] = ~addr_a[mem_addr_width-1];   // Forces a different tag
        run_cmd(cmd_row_load, addr_b, '0, '0, '0, 1'b0);
        addr_w = {addr_b[mem_addr_width-1:idx_width], ~addr_b[idx_width-1:0]};
        run_cmd(cmd_row_load, addr_w, '0, '0, '0, 1'b0);

        repeat (3) @(posedge clk);
        check_rdy_cycles(rdy_total, n_issued, "ready pulses over");
        check_rdy_cycles(store_beats, cache_depth, "DDR store beats over");
        $display("All tests passed!");
        $finish;
    end

endmodule

/* tb_ddr_model.sv */
module tb_ddr_model #(
    parameter int cache_depth    = 16,
    parameter int data_width     = 16,
    parameter int mem_addr_width = 16,
    parameter int ddr_addr_width = 28
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      data_read_req,
    input  logic [ddr_addr_width-1:0] data_read_addr,
    output logic [data_width-1:0]     data_to_cache,
    output logic                      rd_burst_data_valid,
    input  logic                      data_store_req,
    input  logic [data_width-1:0]     data_to_ddr,
    output int                        store_beats
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int idx_width = $clog2(cache_depth);

    logic [data_width-1:0]     ddr_mem [2**mem_addr_width];   // Preloaded by the testbench top
    logic [data_width-1:0]     store_log [cache_depth];
    logic [ddr_addr_width-1:0] rd_ptr;
    int                        rd_beat;
    int                        gap_phase;

    assign rd_ptr = data_read_addr + ddr_addr_width'(rd_beat);

    // Read burst with an idle cycle after every third beat
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            data_to_cache       <= '0;
            rd_burst_data_valid <= 1'b0;
            rd_beat             <= 0;
            gap_phase           <= 0;
        end else if (!data_read_req) begin
            rd_burst_data_valid <= 1'b0;
            rd_beat             <= 0;
            gap_phase           <= 0;
        end else if (rd_beat == cache_depth || gap_phase == 3) begin
            rd_burst_data_valid <= 1'b0;
            gap_phase           <= 0;
        end else begin
            data_to_cache       <= ddr_mem[rd_ptr[mem_addr_width-1:0]];
            rd_burst_data_valid <= 1'b1;
            rd_beat             <= rd_beat + 1;
            gap_phase           <= gap_phase + 1;
        end
    end

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            store_beats <= 0;
        end else if (data_store_req) begin
            store_log[idx_width'(store_beats % cache_depth)] <= data_to_ddr;   // DDR takes every beat
            store_beats <= store_beats + 1;
        end
    end

endmodule
